// File: rtl/snitch_bootrom.hex
// Boot ROM image, one 32-bit hex word per line, word addresses 0 to 31
f1402573
00000297
02028293
30529073
00001597
f0058593
0005a603
00060463
00060067
10500073
ffdff06f
00000013
0ff0000f
0000100f
30047073
00800513
30452073
00100073
c0de0001
c0de0002
b007cafe
5a5a5a5a
a5a5a5a5
0badf00d
12345678
87654321
deadbeef
feedface
00c0ffee
13579bdf
2468ace0
fffffffe

// File: compile.f
+incdir+include
rtl/chimera_pkg.sv
rtl/chimera_apb_demux.sv
rtl/chimera_reg_top.sv
rtl/snitch_bootrom.sv
rtl/chimera_top.sv
dv/chimera_props.sv
dv/tb_chimera_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the Chimera control plane testbench with Verilator

cd "$(dirname "$0")" || exit 1
mkdir -p build && rm -f build/sim.log
verilator --binary --timing --assert -f compile.f --top-module tb_chimera_top \
  -Mdir build/obj_dir -o tb_chimera_top \
  && ./build/obj_dir/tb_chimera_top | tee build/sim.log \
  || { echo "Build did not complete"; exit 1; }
grep -q "Verification failed" build/sim.log && { echo "FAIL"; exit 1; }
grep -q "Verification passed" build/sim.log || { echo "FAIL"; exit 1; }
echo "PASS"

// File: dv/tb_chimera_top.sv
// Testbench for the Chimera control plane
// Drives APB transfers into the top level and checks every response,
// its wait states and the cluster output levels against a reference model

`default_nettype none

`include "chimera_defs.svh"

module tb_chimera_top;

  localparam int unsigned PadWidth    = `CHIMERA_DATA_WIDTH - `CHIMERA_EXT_CLUSTERS;
  localparam int          XferTimeout = 16;
  localparam int          NumRandom   = 200;

  typedef struct packed {
    logic                           data_valid;
    logic                           err;
    logic [`CHIMERA_DATA_WIDTH-1:0] data;
  } exp_rsp_t;

  logic                             soc_clk = 1'b0;
  logic                             arst_n;
  chimera_pkg::apb_req_t            apb_req;
  chimera_pkg::apb_rsp_t            apb_rsp;
  logic [`CHIMERA_EXT_CLUSTERS-1:0] clu_clk_en;
  logic [`CHIMERA_EXT_CLUSTERS-1:0] wide_mem_bypass;

  // Reference model state
  logic [`CHIMERA_EXT_CLUSTERS-1:0] gate_m = '0;
  logic [`CHIMERA_EXT_CLUSTERS-1:0] bypass_m = '0;
  logic [`CHIMERA_DATA_WIDTH-1:0]   rom_m [`CHIMERA_ROM_WORDS];

  logic [31:0] lfsr_state = 32'hfe44eca8;
  int          access_cycles = 0;

  always #5 soc_clk = ~soc_clk;

  chimera_top u_chimera_top (
    .soc_clk_i         (soc_clk),
    .arst_n_i          (arst_n),
    .apb_req_i         (apb_req),
    .apb_rsp_o         (apb_rsp),
    .clu_clk_en_o      (clu_clk_en),
    .wide_mem_bypass_o (wide_mem_bypass)
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
      else fail_run($sformatf("Error at %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic exp_rsp_t expected_resp(input logic wr, input logic [31:0] addr);
    exp_rsp_t    e;
    logic [31:0] region;
    logic [31:0] offs;
    e      = '0;
    region = addr & `CHIMERA_REGION_MASK;
    offs   = addr & ~`CHIMERA_REGION_MASK;
    if (region == `CHIMERA_REG_BASE) begin
      if (offs == `CHIMERA_REG_CLK_GATE_OFFS) begin
        e.data       = {{PadWidth{1'b0}}, gate_m};
        e.data_valid = !wr;
      end else if (offs == `CHIMERA_REG_BYPASS_OFFS) begin
        e.data       = {{PadWidth{1'b0}}, bypass_m};
        e.data_valid = !wr;
      end else begin
        e.err        = 1'b1;
        e.data_valid = 1'b1;
      end
    end else if (region == `CHIMERA_ROM_BASE) begin
      e.err        = wr;
      e.data_valid = 1'b1;
      e.data       = wr ? '0 : rom_m[(addr >> 2) % `CHIMERA_ROM_WORDS];
    end else begin
      e.err        = 1'b1;
      e.data_valid = 1'b1;
    end
    return e;
  endfunction

  task automatic update_model(input logic wr, input logic [31:0] addr,
                              input logic [31:0] wdata);
    if (wr && ((addr & `CHIMERA_REGION_MASK) == `CHIMERA_REG_BASE)) begin
      if ((addr & ~`CHIMERA_REGION_MASK) == `CHIMERA_REG_CLK_GATE_OFFS) begin
        gate_m = wdata[`CHIMERA_EXT_CLUSTERS-1:0];
      end else if ((addr & ~`CHIMERA_REGION_MASK) == `CHIMERA_REG_BYPASS_OFFS) begin
        bypass_m = wdata[`CHIMERA_EXT_CLUSTERS-1:0];
      end
    end
  endtask

  task automatic apb_transfer(input logic wr, input logic [31:0] addr,
                              input logic [31:0] wdata);
    int waited;
    @(posedge soc_clk);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= wr;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    @(posedge soc_clk);
    apb_req.penable <= 1'b1;
    waited = 0;
    do begin
      @(posedge soc_clk);
      waited++;
      assert (waited <= XferTimeout)
        else fail_run($sformatf("Timeout: no pready for the transfer to address %h", addr));
    end while (!apb_rsp.pready);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
  endtask

  task automatic random_transfer();
    logic [1:0]  kind;
    logic [1:0]  offs_sel;
    logic        wr;
    logic [31:0] addr;
    logic [31:0] wdata;
    kind  = 2'(rand_bits(2));
    wr    = 1'(rand_bits(1));
    wdata = rand_bits(32);
    if (kind == 2'd2) begin
      addr = `CHIMERA_ROM_BASE | rand_bits(12);
    end else if (kind == 2'd3) begin
      addr = 32'h0000_2000 + (rand_bits(16) << 12);
      addr = addr + rand_bits(12);
    end else begin
      offs_sel = 2'(rand_bits(2));
      case (offs_sel)
        2'd0:    addr = `CHIMERA_REG_BASE + `CHIMERA_REG_CLK_GATE_OFFS;
        2'd1:    addr = `CHIMERA_REG_BASE + `CHIMERA_REG_BYPASS_OFFS;
        2'd2:    addr = `CHIMERA_REG_BASE + 32'h8;
        default: addr = `CHIMERA_REG_BASE | rand_bits(12);
      endcase
    end
    apb_transfer(wr, addr, wdata);
  endtask

  // Values sampled at the rising edge are the settled ones of the past cycle
  always @(posedge soc_clk) begin : compare_proc
    exp_rsp_t exp_rsp;
    int       exp_cycles;
    if (arst_n) begin
      check_value("clu_clk_en_o", {{PadWidth{1'b0}}, clu_clk_en}, {{PadWidth{1'b0}}, ~gate_m});
      check_value("wide_mem_bypass_o", {{PadWidth{1'b0}}, wide_mem_bypass},
                  {{PadWidth{1'b0}}, bypass_m});
      if (apb_req.psel && apb_req.penable) begin
        access_cycles++;
        if (apb_rsp.pready) begin
          exp_rsp = expected_resp(apb_req.pwrite, apb_req.paddr);
          check_value("pslverr", {31'b0, apb_rsp.pslverr}, {31'b0, exp_rsp.err});
          if (exp_rsp.data_valid) begin
            check_value("prdata", apb_rsp.prdata, exp_rsp.data);
          end
          // ROM has one wait state, everything else none
          exp_cycles = ((apb_req.paddr & `CHIMERA_REGION_MASK) == `CHIMERA_ROM_BASE) ? 2 : 1;
          check_value("access cycles", 32'(access_cycles), 32'(exp_cycles));
          update_model(apb_req.pwrite, apb_req.paddr, apb_req.pwdata);
          access_cycles = 0;
        end
      end
    end
  end

  initial begin : stimulus
    $readmemh("rtl/snitch_bootrom.hex", rom_m);
    arst_n  <= 1'b0;
    apb_req <= '0;
    repeat (4) @(posedge soc_clk);
    arst_n <= 1'b1;

    apb_transfer(1'b0, `CHIMERA_REG_BASE + `CHIMERA_REG_CLK_GATE_OFFS, '0);
    apb_transfer(1'b0, `CHIMERA_REG_BASE + `CHIMERA_REG_BYPASS_OFFS, '0);
    apb_transfer(1'b1, `CHIMERA_REG_BASE + `CHIMERA_REG_CLK_GATE_OFFS, 32'hffff_fff5);
    apb_transfer(1'b0, `CHIMERA_REG_BASE + `CHIMERA_REG_CLK_GATE_OFFS, '0);
    apb_transfer(1'b1, `CHIMERA_REG_BASE + `CHIMERA_REG_BYPASS_OFFS, 32'h0000_002a);
    apb_transfer(1'b0, `CHIMERA_REG_BASE + `CHIMERA_REG_BYPASS_OFFS, '0);

    // ROM reads, the last two wrap at the ROM depth
    apb_transfer(1'b0, `CHIMERA_ROM_BASE, '0);
    apb_transfer(1'b0, `CHIMERA_ROM_BASE + 32'h7c, '0);
    apb_transfer(1'b0, `CHIMERA_ROM_BASE + 32'h80, '0);
    apb_transfer(1'b0, `CHIMERA_ROM_BASE + 32'hffc, '0);
    apb_transfer(1'b1, `CHIMERA_ROM_BASE + 32'h8, 32'h1234_5678);
    apb_transfer(1'b0, `CHIMERA_ROM_BASE + 32'h8, '0);

    apb_transfer(1'b0, 32'h0000_2000, '0);
    apb_transfer(1'b1, 32'hffff_f004, 32'h0000_001f);
    apb_transfer(1'b1, `CHIMERA_REG_BASE + 32'h8, 32'h0000_001f);
    apb_transfer(1'b0, `CHIMERA_REG_BASE + 32'h2, '0);

    for (int i = 0; i < NumRandom; i++) begin
      random_transfer();
    end

    repeat (2) @(posedge soc_clk);
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/chimera_props.sv
// Chimera control plane protocol checks
// APB response rules and stability of the cluster output levels,
// bound onto the top level

`default_nettype none

`include "chimera_defs.svh"

module chimera_props (
  input logic                             soc_clk_i,
  input logic                             arst_n_i,
  input chimera_pkg::apb_req_t             apb_req_i,
  input chimera_pkg::apb_rsp_t             apb_rsp_i,
  input logic [`CHIMERA_EXT_CLUSTERS-1:0] clu_clk_en_i,
  input logic [`CHIMERA_EXT_CLUSTERS-1:0] wide_mem_bypass_i
);

  logic reg_wr_done;

  assign reg_wr_done = apb_req_i.psel && apb_req_i.penable && apb_rsp_i.pready &&
                       apb_req_i.pwrite &&
                       ((apb_req_i.paddr & `CHIMERA_REGION_MASK) == `CHIMERA_REG_BASE);

  pready_in_access_a: assert property (@(posedge soc_clk_i) disable iff (!arst_n_i)
    apb_rsp_i.pready |-> (apb_req_i.psel && apb_req_i.penable))
    else $error("pready high outside an access phase");

  pslverr_with_pready_a: assert property (@(posedge soc_clk_i) disable iff (!arst_n_i)
    apb_rsp_i.pslverr |-> apb_rsp_i.pready)
    else $error("pslverr high without pready");

  // Output levels move only right after a register write
  outputs_stable_a: assert property (@(posedge soc_clk_i) disable iff (!arst_n_i)
    !$past(reg_wr_done) |-> ($stable(clu_clk_en_i) && $stable(wide_mem_bypass_i)))
    else $error("cluster outputs changed without a register write");

endmodule

bind chimera_top chimera_props u_chimera_props (
  .soc_clk_i         (soc_clk_i),
  .arst_n_i          (arst_n_i),
  .apb_req_i         (apb_req_i),
  .apb_rsp_i         (apb_rsp_o),
  .clu_clk_en_i      (clu_clk_en_o),
  .wide_mem_bypass_i (wide_mem_bypass_o)
);

`default_nettype wire

// File: rtl/chimera_top.sv
// Chimera control plane top level
// One APB port decoded onto the configuration registers and the boot ROM

`default_nettype none

`include "chimera_defs.svh"

module chimera_top (
  input  logic                              soc_clk_i,
  input  logic                              arst_n_i,
  input  chimera_pkg::apb_req_t              apb_req_i,
  output chimera_pkg::apb_rsp_t              apb_rsp_o,
  output logic [`CHIMERA_EXT_CLUSTERS-1:0]   clu_clk_en_o,
  output logic [`CHIMERA_EXT_CLUSTERS-1:0]   wide_mem_bypass_o
);

  chimera_pkg::apb_req_t reg_req;
  chimera_pkg::apb_rsp_t reg_rsp;
  chimera_pkg::apb_req_t rom_req;
  chimera_pkg::apb_rsp_t rom_rsp;

  chimera_apb_demux u_apb_demux (
    .soc_clk_i (soc_clk_i),
    .arst_n_i  (arst_n_i),
    .apb_req_i (apb_req_i),
    .apb_rsp_o (apb_rsp_o),
    .reg_req_o (reg_req),
    .reg_rsp_i (reg_rsp),
    .rom_req_o (rom_req),
    .rom_rsp_i (rom_rsp)
  );

  chimera_reg_top u_reg_top (
    .soc_clk_i         (soc_clk_i),
    .arst_n_i          (arst_n_i),
    .reg_req_i         (reg_req),
    .reg_rsp_o         (reg_rsp),
    .clu_clk_en_o      (clu_clk_en_o),
    .wide_mem_bypass_o (wide_mem_bypass_o)
  );

  snitch_bootrom u_bootrom (
    .soc_clk_i (soc_clk_i),
    .arst_n_i  (arst_n_i),
    .rom_req_i (rom_req),
    .rom_rsp_o (rom_rsp)
  );

endmodule

`default_nettype wire

// File: rtl/snitch_bootrom.sv
// Snitch cluster boot ROM with APB adapter
// Read data is registered in the first access cycle and returned in the
// second, like a memory with one cycle of latency. Writes end in an error

`default_nettype none

`include "chimera_defs.svh"

module snitch_bootrom (
  input  logic                 soc_clk_i,
  input  logic                 arst_n_i,
  input  chimera_pkg::apb_req_t rom_req_i,
  output chimera_pkg::apb_rsp_t rom_rsp_o
);

  localparam int unsigned IdxWidth = $clog2(`CHIMERA_ROM_WORDS);

  logic [`CHIMERA_DATA_WIDTH-1:0] rom_mem [`CHIMERA_ROM_WORDS];
  logic [IdxWidth-1:0]            word_idx;
  chimera_pkg::rom_state_e        state_q;
  logic [`CHIMERA_DATA_WIDTH-1:0] rdata_q;
  logic                           err_q;

  initial begin
    $readmemh("rtl/snitch_bootrom.hex", rom_mem);
  end

  // Word address wraps at the ROM depth
  assign word_idx = rom_req_i.paddr[2 +: IdxWidth];

  always_ff @(posedge soc_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= chimera_pkg::ROM_IDLE;
    end else begin
      case (state_q)
        chimera_pkg::ROM_IDLE: begin
          if (rom_req_i.psel && rom_req_i.penable) begin
            state_q <= chimera_pkg::ROM_RESP;
          end
        end
        default: state_q <= chimera_pkg::ROM_IDLE;
      endcase
    end
  end

  always_ff @(posedge soc_clk_i) begin
    if (state_q == chimera_pkg::ROM_IDLE && rom_req_i.psel && rom_req_i.penable) begin
      rdata_q <= rom_req_i.pwrite ? '0 : rom_mem[word_idx];
      err_q   <= rom_req_i.pwrite;
    end
  end

  assign rom_rsp_o.pready  = (state_q == chimera_pkg::ROM_RESP);
  assign rom_rsp_o.prdata  = rdata_q;
  assign rom_rsp_o.pslverr = (state_q == chimera_pkg::ROM_RESP) & err_q;

endmodule

`default_nettype wire

// File: rtl/chimera_reg_top.sv
// Chimera configuration registers
// Per-cluster clock-gate and wide-memory bypass fields, zero wait states.
// The gate field leaves the block inverted as a clock enable level

`default_nettype none

`include "chimera_defs.svh"

module chimera_reg_top (
  input  logic                              soc_clk_i,
  input  logic                              arst_n_i,
  input  chimera_pkg::apb_req_t              reg_req_i,
  output chimera_pkg::apb_rsp_t              reg_rsp_o,
  output logic [`CHIMERA_EXT_CLUSTERS-1:0]   clu_clk_en_o,
  output logic [`CHIMERA_EXT_CLUSTERS-1:0]   wide_mem_bypass_o
);

  localparam int unsigned PadWidth = `CHIMERA_DATA_WIDTH - `CHIMERA_EXT_CLUSTERS;

  logic [`CHIMERA_ADDR_WIDTH-1:0]   offset;
  chimera_pkg::cfg_reg_e            reg_sel;
  logic                             access;
  logic [`CHIMERA_EXT_CLUSTERS-1:0] clk_gate_q;
  logic [`CHIMERA_EXT_CLUSTERS-1:0] bypass_q;
  logic [`CHIMERA_DATA_WIDTH-1:0]   rdata;

  assign offset = reg_req_i.paddr & ~`CHIMERA_REGION_MASK;
  assign access = reg_req_i.psel & reg_req_i.penable;

  always_comb begin
    case (offset)
      `CHIMERA_REG_CLK_GATE_OFFS: reg_sel = chimera_pkg::REG_CLK_GATE;
      `CHIMERA_REG_BYPASS_OFFS:   reg_sel = chimera_pkg::REG_BYPASS;
      default:                    reg_sel = chimera_pkg::REG_NONE;
    endcase
  end

  // Writes land on the access cycle edge, only the low cluster bits are kept
  always_ff @(posedge soc_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      clk_gate_q <= '0;
      bypass_q   <= '0;
    end else if (access && reg_req_i.pwrite) begin
      case (reg_sel)
        chimera_pkg::REG_CLK_GATE: clk_gate_q <= reg_req_i.pwdata[`CHIMERA_EXT_CLUSTERS-1:0];
        chimera_pkg::REG_BYPASS:   bypass_q   <= reg_req_i.pwdata[`CHIMERA_EXT_CLUSTERS-1:0];
        default: ;
      endcase
    end
  end

  always_comb begin
    case (reg_sel)
      chimera_pkg::REG_CLK_GATE: rdata = {{PadWidth{1'b0}}, clk_gate_q};
      chimera_pkg::REG_BYPASS:   rdata = {{PadWidth{1'b0}}, bypass_q};
      default:                   rdata = '0;
    endcase
  end

  assign reg_rsp_o.pready  = access;
  assign reg_rsp_o.prdata  = rdata;
  assign reg_rsp_o.pslverr = access & (reg_sel == chimera_pkg::REG_NONE);

  // Gate bit set means the cluster clock is stopped
  assign clu_clk_en_o      = ~clk_gate_q;
  assign wide_mem_bypass_o = bypass_q;

endmodule

`default_nettype wire

// File: rtl/chimera_apb_demux.sv
// Chimera APB decoder
// Routes each transfer to the register block or the boot ROM and merges
// their responses; unmapped addresses get an error response from here

`default_nettype none

`include "chimera_defs.svh"

module chimera_apb_demux (
  input  logic                 soc_clk_i,
  input  logic                 arst_n_i,
  input  chimera_pkg::apb_req_t apb_req_i,
  output chimera_pkg::apb_rsp_t apb_rsp_o,
  output chimera_pkg::apb_req_t reg_req_o,
  input  chimera_pkg::apb_rsp_t reg_rsp_i,
  output chimera_pkg::apb_req_t rom_req_o,
  input  chimera_pkg::apb_rsp_t rom_rsp_i
);

  logic [`CHIMERA_ADDR_WIDTH-1:0] region;
  logic                           sel_reg;
  logic                           sel_rom;
  logic                           unmapped_q;
  logic                           err_access;

  assign region  = apb_req_i.paddr & `CHIMERA_REGION_MASK;
  assign sel_reg = (region == `CHIMERA_REG_BASE);
  assign sel_rom = (region == `CHIMERA_ROM_BASE);

  // Only the selected target sees psel
  always_comb begin
    reg_req_o      = apb_req_i;
    rom_req_o      = apb_req_i;
    reg_req_o.psel = apb_req_i.psel & sel_reg;
    rom_req_o.psel = apb_req_i.psel & sel_rom;
  end

  // Unmapped transfer seen in setup, cleared once its access phase ends
  always_ff @(posedge soc_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      unmapped_q <= 1'b0;
    end else if (apb_req_i.psel && !apb_req_i.penable) begin
      unmapped_q <= !sel_reg && !sel_rom;
    end else if (apb_req_i.psel && apb_req_i.penable) begin
      unmapped_q <= 1'b0;
    end
  end

  assign err_access = unmapped_q & apb_req_i.psel & apb_req_i.penable;

  always_comb begin
    if (sel_reg) begin
      apb_rsp_o = reg_rsp_i;
    end else if (sel_rom) begin
      apb_rsp_o = rom_rsp_i;
    end else begin
      apb_rsp_o.pready  = err_access;
      apb_rsp_o.prdata  = '0;
      apb_rsp_o.pslverr = err_access;
    end
  end

endmodule

`default_nettype wire

// File: rtl/chimera_pkg.sv
// Chimera control plane types
// APB request and response structs, register select and ROM adapter state

`default_nettype none

`include "chimera_defs.svh"

package chimera_pkg;

  typedef struct packed {
    logic                            psel;
    logic                            penable;
    logic                            pwrite;
    logic [`CHIMERA_ADDR_WIDTH-1:0]  paddr;
    logic [`CHIMERA_DATA_WIDTH-1:0]  pwdata;
  } apb_req_t;

  typedef struct packed {
    logic                            pready;
    logic [`CHIMERA_DATA_WIDTH-1:0]  prdata;
    logic                            pslverr;
  } apb_rsp_t;

  typedef enum logic [1:0] {REG_CLK_GATE, REG_BYPASS, REG_NONE} cfg_reg_e;

  typedef enum logic {ROM_IDLE, ROM_RESP} rom_state_e;

endpackage

`default_nettype wire

// File: include/chimera_defs.svh
// Chimera control plane constants
// Widths, cluster count, boot ROM depth and the APB address map

`ifndef CHIMERA_DEFS_SVH
`define CHIMERA_DEFS_SVH

`define CHIMERA_EXT_CLUSTERS 5

`define CHIMERA_ADDR_WIDTH 32
`define CHIMERA_DATA_WIDTH 32

`define CHIMERA_ROM_WORDS 32

// Two 4 KiB regions
`define CHIMERA_REG_BASE 32'h0000_0000
`define CHIMERA_ROM_BASE 32'h0000_1000
`define CHIMERA_REGION_MASK 32'hFFFF_F000

`define CHIMERA_REG_CLK_GATE_OFFS 32'h0
`define CHIMERA_REG_BYPASS_OFFS 32'h4

`endif
